/* bus_master_port.sv */
`timescale 1ns/1ps

module bus_master_port (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  bus_pkg::instr_t   instruction,
	input  bus_pkg::addr_t    address,
	input  bus_pkg::data_t    wr_data,
	output logic              trans_done,
	output bus_pkg::data_t    rd_data,
	output logic              bus_frame,
	output logic              bus_mosi,
	input  logic              bus_miso
);

	bus_pkg::bit_cnt_t bit_cnt; // index of the bit on the bus
	logic [bus_pkg::WR_FRAME_LEN-1:0] shift_reg;
	logic is_read;
	logic last_bit;
	logic load;
	bus_pkg::data_t frame_data;

	assign load = start & ~bus_frame;

	// a read frame carries zeros in the data slot
	assign frame_data = (instruction == bus_pkg::INSTR_WRITE) ? wr_data : '0;

	assign last_bit = is_read ?
		(bit_cnt == bus_pkg::bit_cnt_t'(bus_pkg::RD_FRAME_LEN - 1)) :
		(bit_cnt == bus_pkg::bit_cnt_t'(bus_pkg::WR_FRAME_LEN - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			bus_frame <= 1'b0;
			bit_cnt <= '0;
			is_read <= 1'b0;
			trans_done <= 1'b0;
		end
		else
		begin
			trans_done <= 1'b0;
			if (load)
			begin
				bus_frame <= 1'b1; // first bit goes out next cycle
				bit_cnt <= '0;
				is_read <= (instruction == bus_pkg::INSTR_READ);
			end
			else if (bus_frame)
			begin
				if (last_bit)
				begin
					bus_frame <= 1'b0;
					trans_done <= 1'b1; // one cycle after the last bit
				end
				else
				begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift_reg <= {instruction, bus_pkg::RAM_SLAVE_ID, address, frame_data};
		else if (bus_frame)
			shift_reg <= {shift_reg[bus_pkg::WR_FRAME_LEN-2:0], 1'b0}; // MSB first

		// slave drives miso after the turnaround cycle
		if (bus_frame && is_read && bit_cnt > bus_pkg::bit_cnt_t'(bus_pkg::HEADER_LEN))
			rd_data <= {rd_data[bus_pkg::DATA_LEN-2:0], bus_miso};
	end

	assign bus_mosi = bus_frame & shift_reg[bus_pkg::WR_FRAME_LEN-1];

endmodule

/* bus_pkg.sv */
package bus_pkg;

	// RAM and data widths, fixed by the frame format
	localparam int ADDR_LEN = 12;
	localparam int DATA_LEN = 8;
	localparam int INSTR_LEN = 2;
	localparam int SLAVE_LEN = 2;
	localparam int NIBBLE_LEN = 4;
	localparam int SEG_LEN = 7;

	typedef logic [ADDR_LEN-1:0] addr_t;
	typedef logic [DATA_LEN-1:0] data_t;
	typedef logic [INSTR_LEN-1:0] instr_t;
	typedef logic [SLAVE_LEN-1:0] slave_id_t;
	typedef logic [NIBBLE_LEN-1:0] nibble_t;
	typedef logic [SEG_LEN-1:0] seg_t; // g..a, active high

	// bus instruction codes
	localparam instr_t INSTR_IDLE = 2'b00;
	localparam instr_t INSTR_WRITE = 2'b10;
	localparam instr_t INSTR_READ = 2'b11;

	localparam slave_id_t RAM_SLAVE_ID = 2'd1; // only slave on the bus

	// frame layout: instr, id, addr, then data or turnaround + read data
	localparam int HEADER_LEN = INSTR_LEN + SLAVE_LEN + ADDR_LEN;
	localparam int WR_FRAME_LEN = HEADER_LEN + DATA_LEN;
	localparam int RD_FRAME_LEN = HEADER_LEN + 1 + DATA_LEN;

	localparam int CNT_LEN = $clog2(RD_FRAME_LEN + 1);
	typedef logic [CNT_LEN-1:0] bit_cnt_t; // bit index inside a frame

endpackage

/* bus_slave_ram.sv */
`timescale 1ns/1ps

module bus_slave_ram (
	input  logic clk,
	input  logic reset,
	input  logic bus_frame,
	input  logic bus_mosi,
	output logic bus_miso
);

	localparam int RAM_DEPTH = 1 << bus_pkg::ADDR_LEN;

	bus_pkg::data_t mem [RAM_DEPTH];

	bus_pkg::bit_cnt_t cnt; // bits seen in the current frame
	logic in_frame;
	logic drive; // miso owned by this slave
	logic [bus_pkg::HEADER_LEN-1:0] hdr;
	bus_pkg::data_t wdata;
	bus_pkg::data_t rd_q; // RAM read register
	bus_pkg::data_t out_sr;

	bus_pkg::instr_t hdr_instr;
	bus_pkg::slave_id_t hdr_id;
	bus_pkg::addr_t hdr_addr;
	bus_pkg::addr_t rd_addr;
	logic id_ok;
	logic wr_hit;
	logic rd_issue;
	logic load_out;

	assign hdr_instr = hdr[bus_pkg::HEADER_LEN-1 -: bus_pkg::INSTR_LEN];
	assign hdr_id = hdr[bus_pkg::ADDR_LEN +: bus_pkg::SLAVE_LEN];
	assign hdr_addr = hdr[bus_pkg::ADDR_LEN-1:0];
	assign id_ok = (hdr_id == bus_pkg::RAM_SLAVE_ID);

	// last header bit completes the address, so the read is issued here
	// and the data sits in rd_q during the turnaround cycle
	assign rd_addr = {hdr[bus_pkg::ADDR_LEN-2:0], bus_mosi};
	assign rd_issue = bus_frame && (cnt == bus_pkg::bit_cnt_t'(bus_pkg::HEADER_LEN - 1));

	assign load_out = bus_frame && (cnt == bus_pkg::bit_cnt_t'(bus_pkg::HEADER_LEN))
		&& id_ok && (hdr_instr == bus_pkg::INSTR_READ);

	// commit a complete write frame once bus_frame drops
	assign wr_hit = in_frame && !bus_frame && id_ok
		&& (hdr_instr == bus_pkg::INSTR_WRITE)
		&& (cnt == bus_pkg::bit_cnt_t'(bus_pkg::WR_FRAME_LEN));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			in_frame <= 1'b0;
			drive <= 1'b0;
		end
		else
		begin
			in_frame <= bus_frame;
			if (bus_frame)
				cnt <= cnt + 1'b1;
			else
				cnt <= '0;

			if (load_out)
				drive <= 1'b1;
			else if (!bus_frame || cnt == bus_pkg::bit_cnt_t'(bus_pkg::RD_FRAME_LEN - 1))
				drive <= 1'b0; // release after the 8th data bit
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus_frame && cnt < bus_pkg::bit_cnt_t'(bus_pkg::HEADER_LEN))
			hdr <= {hdr[bus_pkg::HEADER_LEN-2:0], bus_mosi};
		if (bus_frame && cnt >= bus_pkg::bit_cnt_t'(bus_pkg::HEADER_LEN))
			wdata <= {wdata[bus_pkg::DATA_LEN-2:0], bus_mosi}; // write payload

		if (load_out)
			out_sr <= rd_q;
		else if (drive)
			out_sr <= {out_sr[bus_pkg::DATA_LEN-2:0], 1'b0};
	end

	// block RAM, one write port and one registered read port
	always_ff @(posedge clk)
	begin
		if (wr_hit)
			mem[hdr_addr] <= wdata;
		if (rd_issue)
			rd_q <= mem[rd_addr];
	end

	assign bus_miso = drive & out_sr[bus_pkg::DATA_LEN-1]; // low unless addressed

endmodule

/* button_bus_top.sv */
`timescale 1ns/1ps

module button_bus_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            button1,
	input  logic            button2,
	input  bus_pkg::addr_t  sw_addr,
	input  bus_pkg::data_t  sw_data,
	output logic            busy,
	output bus_pkg::seg_t   display_hi,
	output bus_pkg::seg_t   display_lo
);

	logic press1;
	logic press2;
	logic start;
	logic trans_done;
	bus_pkg::instr_t instruction;
	bus_pkg::addr_t address;
	bus_pkg::data_t wr_data;
	bus_pkg::data_t rd_data;
	bus_pkg::data_t rx_val; // last byte read back
	logic bus_frame;
	logic bus_mosi;
	logic bus_miso;

	button_sync i_sync1 (.clk(clk), .reset(reset), .button(button1), .press(press1));
	button_sync i_sync2 (.clk(clk), .reset(reset), .button(button2), .press(press2));

	button_event_ctrl i_ctrl (
		.clk(clk), .reset(reset),
		.press1(press1), .press2(press2),
		.sw_addr(sw_addr), .sw_data(sw_data),
		.trans_done(trans_done), .rd_data(rd_data),
		.start(start), .instruction(instruction),
		.address(address), .wr_data(wr_data),
		.busy(busy), .rx_val(rx_val)
	);

	bus_master_port i_master (
		.clk(clk), .reset(reset),
		.start(start), .instruction(instruction),
		.address(address), .wr_data(wr_data),
		.trans_done(trans_done), .rd_data(rd_data),
		.bus_frame(bus_frame), .bus_mosi(bus_mosi), .bus_miso(bus_miso)
	);

	bus_slave_ram i_ram (
		.clk(clk), .reset(reset),
		.bus_frame(bus_frame), .bus_mosi(bus_mosi), .bus_miso(bus_miso)
	);

	seg7_decoder i_seg_hi (.value(rx_val[7:4]), .seg(display_hi)); // high nibble
	seg7_decoder i_seg_lo (.value(rx_val[3:0]), .seg(display_lo));

endmodule

/* button_event_ctrl.sv */
`timescale 1ns/1ps

module button_event_ctrl (
	input  logic              clk,
	input  logic              reset,
	input  logic              press1,
	input  logic              press2,
	input  bus_pkg::addr_t    sw_addr,
	input  bus_pkg::data_t    sw_data,
	input  logic              trans_done,
	input  bus_pkg::data_t    rd_data,
	output logic              start,
	output bus_pkg::instr_t   instruction,
	output bus_pkg::addr_t    address,
	output bus_pkg::data_t    wr_data,
	output logic              busy,
	output bus_pkg::data_t    rx_val
);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_WAIT,
		READ_WAIT
	} state_t;

	state_t state;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			start <= 1'b0;
			busy <= 1'b0;
			instruction <= bus_pkg::INSTR_IDLE;
			rx_val <= '0;
		end
		else
		begin
			start <= 1'b0; // single cycle strobe
			case (state)
				IDLE:
				begin
					if (press1) // button 1 wins a tie
					begin
						state <= WRITE_WAIT;
						instruction <= bus_pkg::INSTR_WRITE;
						start <= 1'b1;
						busy <= 1'b1;
					end
					else if (press2)
					begin
						state <= READ_WAIT;
						instruction <= bus_pkg::INSTR_READ;
						start <= 1'b1;
						busy <= 1'b1;
					end
				end
				WRITE_WAIT:
				begin
					if (trans_done)
					begin
						state <= IDLE;
						instruction <= bus_pkg::INSTR_IDLE;
						busy <= 1'b0;
					end
				end
				READ_WAIT:
				begin
					if (trans_done)
					begin
						state <= IDLE;
						instruction <= bus_pkg::INSTR_IDLE;
						busy <= 1'b0;
						rx_val <= rd_data; // byte for the displays
					end
				end
				default:
				begin
					state <= IDLE;
					instruction <= bus_pkg::INSTR_IDLE;
					busy <= 1'b0;
				end
			endcase
		end
	end

	// switch values are sampled only when a transaction starts
	always_ff @(posedge clk)
	begin
		if (state == IDLE && (press1 || press2))
			address <= sw_addr;
		if (state == IDLE && press1)
			wr_data <= sw_data;
	end

endmodule

/* button_sync.sv */
`timescale 1ns/1ps

module button_sync (
	input  logic clk,
	input  logic reset,
	input  logic button, // active low
	output logic press
);

	logic sync_0;
	logic sync_1;
	logic sync_prev; // last synchronised level

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sync_0 <= 1'b1; // released
			sync_1 <= 1'b1;
			sync_prev <= 1'b1;
			press <= 1'b0;
		end
		else
		begin
			sync_0 <= button;
			sync_1 <= sync_0;
			sync_prev <= sync_1;
			press <= sync_prev & ~sync_1; // falling edge = press
		end
	end

endmodule

/* seg7_decoder.sv */
`timescale 1ns/1ps

module seg7_decoder (
	input  bus_pkg::nibble_t value,
	output bus_pkg::seg_t    seg
);

	always_comb
	begin
		case (value)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c; // lower case b
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e; // lower case d
			4'he: seg = 7'h79;
			default: seg = 7'h71; // F
		endcase
	end

endmodule

/* sources.f */
bus_pkg.sv
button_sync.sv
button_event_ctrl.sv
bus_master_port.sv
bus_slave_ram.sv
seg7_decoder.sv
button_bus_top.sv
tb_button_bus.sv

/* tb_button_bus.sv */
`timescale 1ns/1ps

module tb_button_bus;

	typedef enum {
		OP_WRITE, // button 1 alone
		OP_READ, // button 2 alone
		OP_BOTH, // both buttons in the same cycle
		OP_BUSY // write, then button 2 while busy
	} op_t;

	localparam int NUM_ENTRIES = 18;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 60 + RESET_CYCLES;

	logic clk;
	logic reset;
	logic button1;
	logic button2;
	bus_pkg::addr_t sw_addr;
	bus_pkg::data_t sw_data;
	logic busy;
	bus_pkg::seg_t display_hi;
	bus_pkg::seg_t display_lo;

	// stimulus and expected displayed byte, one row per entry
	op_t op_tab [NUM_ENTRIES];
	logic [11:0] addr_tab [NUM_ENTRIES];
	logic [7:0] data_tab [NUM_ENTRIES];
	logic [7:0] exp_tab [NUM_ENTRIES];
	int n_entries;

	logic [7:0] model_mem [logic [11:0]]; // bytes written so far, by address
	logic [7:0] last_rx; // byte the displays should show

	// segments g..a, active high
	logic [6:0] glyph_tab [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	logic [31:0] lfsr_state;
	int cycle_cnt = 0;

	button_bus_top i_dut (
		.clk(clk),
		.reset(reset),
		.button1(button1),
		.button2(button2),
		.sw_addr(sw_addr),
		.sw_data(sw_data),
		.busy(busy),
		.display_hi(display_hi),
		.display_lo(display_lo)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("the run timed out after %0d clock cycles", cycle_cnt);
			report_failure();
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			report_failure();
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]}; // one step per bit
		end
	endtask

	// appends a row and advances the reference model
	task automatic add_entry(input op_t op, input logic [11:0] addr, input logic [7:0] data);
		if (op == OP_READ)
			last_rx = model_mem[addr];
		else
			model_mem[addr] = data; // writes never touch the displays
		op_tab[n_entries] = op;
		addr_tab[n_entries] = addr;
		data_tab[n_entries] = data;
		exp_tab[n_entries] = last_rx;
		n_entries++;
	endtask

	task automatic build_table();
		logic [31:0] v;
		logic [11:0] r_addr [3];
		add_entry(OP_WRITE, 12'h123, 8'ha5);
		add_entry(OP_READ, 12'h123, 8'h00);
		take_bits(8, v);
		add_entry(OP_WRITE, 12'h000, v[7:0]);
		take_bits(8, v);
		add_entry(OP_WRITE, 12'hfff, v[7:0]);
		for (int i = 0; i < 3; i++)
		begin
			take_bits(12, v);
			r_addr[i] = v[11:0];
			take_bits(8, v);
			add_entry(OP_WRITE, r_addr[i], v[7:0]);
		end
		// read back in a shuffled order
		add_entry(OP_READ, r_addr[2], 8'h00);
		add_entry(OP_READ, 12'hfff, 8'h00);
		add_entry(OP_READ, r_addr[0], 8'h00);
		add_entry(OP_READ, 12'h000, 8'h00);
		add_entry(OP_READ, r_addr[1], 8'h00);
		take_bits(8, v);
		add_entry(OP_WRITE, r_addr[1], v[7:0]); // overwrite
		add_entry(OP_READ, r_addr[1], 8'h00);
		add_entry(OP_BOTH, 12'h123, 8'h3c);
		add_entry(OP_READ, 12'h123, 8'h00);
		add_entry(OP_BUSY, 12'h800, 8'h5a);
		add_entry(OP_READ, 12'h800, 8'h00);
	endtask

	task automatic press_buttons(input logic b1, input logic b2, input logic [11:0] addr,
		input logic [7:0] data);
		@(negedge clk);
		sw_addr = addr;
		sw_data = data;
		button1 = ~b1; // active low
		button2 = ~b2;
		repeat (4) @(negedge clk);
		button1 = 1'b1;
		button2 = 1'b1;
		check_value("busy", busy, 32'd1);
	endtask

	task automatic wait_busy_low();
		while (busy !== 1'b0)
			@(negedge clk);
	endtask

	task automatic check_displays(input logic [7:0] exp);
		check_value("display_hi", display_hi, glyph_tab[exp[7:4]]);
		check_value("display_lo", display_lo, glyph_tab[exp[3:0]]);
	endtask

	task automatic apply_entry(input int e);
		case (op_tab[e])
			OP_WRITE: press_buttons(1'b1, 1'b0, addr_tab[e], data_tab[e]);
			OP_READ: press_buttons(1'b0, 1'b1, addr_tab[e], data_tab[e]);
			OP_BOTH: press_buttons(1'b1, 1'b1, addr_tab[e], data_tab[e]);
			default:
			begin
				press_buttons(1'b1, 1'b0, addr_tab[e], data_tab[e]);
				press_buttons(1'b0, 1'b1, addr_tab[e], data_tab[e]); // lands mid write
			end
		endcase
		wait_busy_low();
		check_displays(exp_tab[e]);
		if (op_tab[e] == OP_BUSY)
		begin
			repeat (20)
			begin
				@(negedge clk);
				check_value("busy", busy, 32'd0); // dropped press must not start a read
			end
			check_displays(exp_tab[e]);
		end
	endtask

	initial
	begin
		button1 = 1'b1;
		button2 = 1'b1;
		sw_addr = '0;
		sw_data = '0;
		reset = 1'b1;
		lfsr_state = 32'hb985;
		n_entries = 0;
		last_rx = 8'h00; // displays read 00 after reset
		build_table();

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("busy", busy, 32'd0);
		check_displays(8'h00);

		for (int e = 0; e < n_entries; e++)
			apply_entry(e);

		$display("PASS: all tests");
		$finish;
	end

endmodule
